// ==== rtl/dcache_pkg.sv ====
package dcache_pkg;

  //////////////////////////////
  // sizes
  //////////////////////////////
  localparam int addr_width   = 32;
  localparam int data_width   = 64;
  localparam int offset_bits  = 3;
  localparam int num_ways     = 2;
  localparam int num_sets     = 16;
  localparam int index_bits   = 4;
  localparam int tag_bits     = addr_width - index_bits - offset_bits;
  localparam int queue_depth  = 4;

  // zero tag on the memory bus means no transaction
  localparam int mem_tag_bits = 4;

  //////////////////////////////
  // memory bus commands
  //////////////////////////////
  localparam logic [1:0] bus_none = 2'h0;
  localparam logic [1:0] bus_load = 2'h1;

  //////////////////////////////
  // address views
  //////////////////////////////
  typedef struct packed {
    logic [tag_bits-1:0]    tag;
    logic [index_bits-1:0]  index;
    logic [offset_bits-1:0] offset;
  } dcache_fields_t;

  // raw byte address, or split into tag / set / byte offset
  typedef union packed {
    logic [addr_width-1:0] raw;
    dcache_fields_t        fields;
  } dcache_addr_t;

endpackage

// ==== rtl/dcache_array.sv ====
`timescale 1ns/100ps

module dcache_array (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                rd_en,
  input  logic [dcache_pkg::addr_width-1:0]   rd_addr,
  output logic [dcache_pkg::data_width-1:0]   rd_data,
  output logic                                rd_valid,
  output logic                                lookup_miss,
  input  logic                                wr_en,
  input  logic [dcache_pkg::addr_width-1:0]   wr_addr,
  input  logic [dcache_pkg::data_width-1:0]   wr_data,
  input  logic                                refill_en,
  input  logic [dcache_pkg::addr_width-1:0]   refill_addr,
  input  logic [dcache_pkg::data_width-1:0]   refill_data,
  output logic                                evicted_valid,
  output logic [dcache_pkg::addr_width-1:0]   evicted_addr,
  output logic [dcache_pkg::data_width-1:0]   evicted_data
);

  //////////////////////////////
  // storage
  //////////////////////////////
  logic [dcache_pkg::tag_bits-1:0]   tag_mem  [dcache_pkg::num_sets][dcache_pkg::num_ways];
  logic [dcache_pkg::data_width-1:0] data_mem [dcache_pkg::num_sets][dcache_pkg::num_ways];
  logic [dcache_pkg::num_ways-1:0]   valid_mem [dcache_pkg::num_sets];
  logic [dcache_pkg::num_ways-1:0]   dirty_mem [dcache_pkg::num_sets];
  // one bit per set, names the way to replace next
  logic [dcache_pkg::num_sets-1:0]   lru;

  dcache_pkg::dcache_addr_t rd_split;
  dcache_pkg::dcache_addr_t wr_split;
  dcache_pkg::dcache_addr_t rf_split;
  dcache_pkg::dcache_addr_t ev_split;

  logic [dcache_pkg::index_bits-1:0] rd_set;
  logic [dcache_pkg::index_bits-1:0] wr_set;
  logic [dcache_pkg::index_bits-1:0] rf_set;
  logic [dcache_pkg::index_bits-1:0] ev_set;
  logic [1:0] rd_probe;
  logic [1:0] wr_probe;
  logic [1:0] rf_probe;
  logic       rd_way;
  logic       wr_way;
  logic       rf_way;
  logic       ev_way;
  logic       wr_evict;
  logic       rf_evict;
  logic       rf_go;

  // returns {hit, way} for one set and tag
  function automatic logic [1:0] probe(input logic [dcache_pkg::index_bits-1:0] set,
                                       input logic [dcache_pkg::tag_bits-1:0] tag);
    logic hit;
    logic way;
    hit = 1'b0;
    way = 1'b0;
    for (int w = 0; w < dcache_pkg::num_ways; w++) begin
      if (valid_mem[set][w] && tag_mem[set][w] == tag) begin
        hit = 1'b1;
        way = 1'(w);
      end
    end
    return {hit, way};
  endfunction

  assign rd_split.raw = rd_addr;
  assign wr_split.raw = wr_addr;
  assign rf_split.raw = refill_addr;
  assign rd_set = rd_split.fields.index;
  assign wr_set = wr_split.fields.index;
  assign rf_set = rf_split.fields.index;

  always_comb begin
    rd_probe = probe(rd_set, rd_split.fields.tag);
    wr_probe = probe(wr_set, wr_split.fields.tag);
    rf_probe = probe(rf_set, rf_split.fields.tag);
  end

  //////////////////////////////
  // lookup
  //////////////////////////////
  assign rd_way      = rd_probe[0];
  assign rd_valid    = rd_en & rd_probe[1];
  assign lookup_miss = rd_en & ~rd_probe[1];
  assign rd_data     = data_mem[rd_set][rd_way];

  // hitting way, else the lru way
  assign wr_way   = wr_probe[1] ? wr_probe[0] : lru[wr_set];
  assign rf_way   = lru[rf_set];
  assign wr_evict = wr_en & ~wr_probe[1] & valid_mem[wr_set][wr_way] & dirty_mem[wr_set][wr_way];
  assign rf_evict = valid_mem[rf_set][rf_way] & dirty_mem[rf_set][rf_way];

  // refill yields to a write in its set, and to a write while it would evict too
  assign rf_go = refill_en & ~rf_probe[1] & ~(wr_en & ((wr_set == rf_set) | rf_evict));

  always_comb begin
    ev_set = wr_evict ? wr_set : rf_set;
    ev_way = wr_evict ? wr_way : rf_way;
    ev_split.fields.tag    = tag_mem[ev_set][ev_way];
    ev_split.fields.index  = ev_set;
    ev_split.fields.offset = '0;
  end

  //////////////////////////////
  // update
  //////////////////////////////
  always_ff @(posedge clock) begin
    if (rf_go) begin
      tag_mem[rf_set][rf_way]  <= rf_split.fields.tag;
      data_mem[rf_set][rf_way] <= refill_data;
    end
    if (wr_en) begin
      tag_mem[wr_set][wr_way]  <= wr_split.fields.tag;
      data_mem[wr_set][wr_way] <= wr_data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int s = 0; s < dcache_pkg::num_sets; s++) begin
        valid_mem[s] <= '0;
        dirty_mem[s] <= '0;
      end
      lru           <= '0;
      evicted_valid <= 1'b0;
    end else begin
      if (rd_valid) begin
        lru[rd_set] <= ~rd_way;
      end
      if (rf_go) begin
        valid_mem[rf_set][rf_way] <= 1'b1;
        dirty_mem[rf_set][rf_way] <= 1'b0;
        lru[rf_set]               <= ~rf_way;
      end
      // write last so it wins the lru bit
      if (wr_en) begin
        valid_mem[wr_set][wr_way] <= 1'b1;
        dirty_mem[wr_set][wr_way] <= 1'b1;
        lru[wr_set]               <= ~wr_way;
      end
      evicted_valid <= wr_evict | (rf_go & rf_evict);
    end
  end

  always_ff @(posedge clock) begin
    if (wr_evict || (rf_go && rf_evict)) begin
      evicted_addr <= ev_split.raw;
      evicted_data <= data_mem[ev_set][ev_way];
    end
  end

endmodule

// ==== rtl/miss_queue.sv ====
`timescale 1ns/100ps

module miss_queue (
  input  logic                                 clock,
  input  logic                                 reset,
  input  logic                                 lookup_miss,
  input  logic [dcache_pkg::addr_width-1:0]    rd_addr,
  output logic                                 refill_en,
  output logic [dcache_pkg::addr_width-1:0]    refill_addr,
  output logic [dcache_pkg::data_width-1:0]    refill_data,
  output logic [1:0]                           proc_mem_command,
  output logic [dcache_pkg::addr_width-1:0]    proc_mem_addr,
  input  logic [dcache_pkg::mem_tag_bits-1:0]  mem_response,
  input  logic [dcache_pkg::data_width-1:0]    mem_data,
  input  logic [dcache_pkg::mem_tag_bits-1:0]  mem_tag
);

  //////////////////////////////
  // queue state
  //////////////////////////////
  logic [dcache_pkg::tag_bits-1:0]     q_line_tag        [dcache_pkg::queue_depth];
  logic [dcache_pkg::tag_bits-1:0]     q_line_tag_next   [dcache_pkg::queue_depth];
  logic [dcache_pkg::index_bits-1:0]   q_line_index      [dcache_pkg::queue_depth];
  logic [dcache_pkg::index_bits-1:0]   q_line_index_next [dcache_pkg::queue_depth];
  logic [dcache_pkg::mem_tag_bits-1:0] q_mem_tag         [dcache_pkg::queue_depth];
  logic [dcache_pkg::mem_tag_bits-1:0] q_mem_tag_next    [dcache_pkg::queue_depth];
  logic [dcache_pkg::queue_depth-1:0]  q_done;
  logic [dcache_pkg::queue_depth-1:0]  q_done_next;

  // entries below tail are live, below send_ptr issued, below wait_ptr returned
  logic [$clog2(dcache_pkg::queue_depth):0] tail;
  logic [$clog2(dcache_pkg::queue_depth):0] tail_next;
  logic [$clog2(dcache_pkg::queue_depth):0] send_ptr;
  logic [$clog2(dcache_pkg::queue_depth):0] send_next;
  logic [$clog2(dcache_pkg::queue_depth):0] wait_ptr;
  logic [$clog2(dcache_pkg::queue_depth):0] wait_next;

  logic [$clog2(dcache_pkg::queue_depth)-1:0] send_idx;
  logic [$clog2(dcache_pkg::queue_depth)-1:0] wait_idx;

  dcache_pkg::dcache_addr_t miss_split;

  logic send_valid;
  logic accept;
  logic match;
  logic dup;

  // rebuild a word address from a queued line
  function automatic logic [dcache_pkg::addr_width-1:0] line_addr(
      input logic [dcache_pkg::tag_bits-1:0]   tag,
      input logic [dcache_pkg::index_bits-1:0] index);
    dcache_pkg::dcache_addr_t a;
    a.fields.tag    = tag;
    a.fields.index  = index;
    a.fields.offset = '0;
    return a.raw;
  endfunction

  assign miss_split.raw = rd_addr;
  assign send_idx = send_ptr[$clog2(dcache_pkg::queue_depth)-1:0];
  assign wait_idx = wait_ptr[$clog2(dcache_pkg::queue_depth)-1:0];

  //////////////////////////////
  // memory request
  //////////////////////////////
  assign send_valid       = send_ptr < tail;
  assign accept           = send_valid && (mem_response != '0);
  assign proc_mem_command = send_valid ? dcache_pkg::bus_load : dcache_pkg::bus_none;
  assign proc_mem_addr    = send_valid ? line_addr(q_line_tag[send_idx], q_line_index[send_idx])
                                       : '0;

  // loads come back in order, so only the oldest unanswered one can match
  assign match = (wait_ptr < send_ptr) && (mem_tag != '0) && (q_mem_tag[wait_idx] == mem_tag);

  always_comb begin
    dup = 1'b0;
    for (int i = 0; i < dcache_pkg::queue_depth; i++) begin
      if (i < tail && q_line_tag[i] == miss_split.fields.tag &&
          q_line_index[i] == miss_split.fields.index) begin
        dup = 1'b1;
      end
    end
  end

  //////////////////////////////
  // next state
  //////////////////////////////
  always_comb begin
    q_line_tag_next   = q_line_tag;
    q_line_index_next = q_line_index;
    q_mem_tag_next    = q_mem_tag;
    q_done_next       = q_done;
    tail_next         = tail;
    send_next         = send_ptr;
    wait_next         = wait_ptr;

    if (match) begin
      q_done_next[wait_idx] = 1'b1;
      wait_next = wait_next + 1'b1;
    end

    // a returned head leaves one cycle after its match
    if (q_done[0]) begin
      for (int i = 0; i < dcache_pkg::queue_depth - 1; i++) begin
        q_line_tag_next[i]   = q_line_tag_next[i+1];
        q_line_index_next[i] = q_line_index_next[i+1];
        q_mem_tag_next[i]    = q_mem_tag_next[i+1];
        q_done_next[i]       = q_done_next[i+1];
      end
      q_done_next[dcache_pkg::queue_depth-1] = 1'b0;
      tail_next = tail_next - 1'b1;
      send_next = send_next - 1'b1;
      wait_next = wait_next - 1'b1;
    end

    // accepted entry sits at send_next once the shift is applied
    if (accept) begin
      q_mem_tag_next[send_next[$clog2(dcache_pkg::queue_depth)-1:0]] = mem_response;
      send_next = send_next + 1'b1;
    end

    if (lookup_miss && !dup && tail_next < dcache_pkg::queue_depth) begin
      q_line_tag_next[tail_next[$clog2(dcache_pkg::queue_depth)-1:0]]   = miss_split.fields.tag;
      q_line_index_next[tail_next[$clog2(dcache_pkg::queue_depth)-1:0]] = miss_split.fields.index;
      q_done_next[tail_next[$clog2(dcache_pkg::queue_depth)-1:0]]       = 1'b0;
      tail_next = tail_next + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      q_done    <= '0;
      tail      <= '0;
      send_ptr  <= '0;
      wait_ptr  <= '0;
      refill_en <= 1'b0;
    end else begin
      q_done    <= q_done_next;
      tail      <= tail_next;
      send_ptr  <= send_next;
      wait_ptr  <= wait_next;
      refill_en <= match;
    end
  end

  always_ff @(posedge clock) begin
    q_line_tag   <= q_line_tag_next;
    q_line_index <= q_line_index_next;
    q_mem_tag    <= q_mem_tag_next;
    if (match) begin
      refill_addr <= line_addr(q_line_tag[wait_idx], q_line_index[wait_idx]);
      refill_data <= mem_data;
    end
  end

endmodule

// ==== rtl/dcache.sv ====
`timescale 1ns/100ps

module dcache (
  input  logic                                 clock,
  input  logic                                 reset,
  input  logic                                 rd_en,
  input  logic [dcache_pkg::addr_width-1:0]    rd_addr,
  output logic [dcache_pkg::data_width-1:0]    rd_data,
  output logic                                 rd_valid,
  output logic                                 rd_miss_valid,
  output logic [dcache_pkg::addr_width-1:0]    rd_miss_addr,
  output logic [dcache_pkg::data_width-1:0]    rd_miss_data,
  input  logic                                 wr_en,
  input  logic [dcache_pkg::addr_width-1:0]    wr_addr,
  input  logic [dcache_pkg::data_width-1:0]    wr_data,
  output logic                                 evicted_valid,
  output logic [dcache_pkg::addr_width-1:0]    evicted_addr,
  output logic [dcache_pkg::data_width-1:0]    evicted_data,
  output logic [1:0]                           proc_mem_command,
  output logic [dcache_pkg::addr_width-1:0]    proc_mem_addr,
  input  logic [dcache_pkg::mem_tag_bits-1:0]  mem_response,
  input  logic [dcache_pkg::data_width-1:0]    mem_data,
  input  logic [dcache_pkg::mem_tag_bits-1:0]  mem_tag
);

  logic                              lookup_miss;
  logic                              refill_en;
  logic [dcache_pkg::addr_width-1:0] refill_addr;
  logic [dcache_pkg::data_width-1:0] refill_data;

  // the refill doubles as the miss completion
  assign rd_miss_valid = refill_en;
  assign rd_miss_addr  = refill_addr;
  assign rd_miss_data  = refill_data;

  dcache_array i_dcache_array (
    .clock         (clock),
    .reset         (reset),
    .rd_en         (rd_en),
    .rd_addr       (rd_addr),
    .rd_data       (rd_data),
    .rd_valid      (rd_valid),
    .lookup_miss   (lookup_miss),
    .wr_en         (wr_en),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .refill_en     (refill_en),
    .refill_addr   (refill_addr),
    .refill_data   (refill_data),
    .evicted_valid (evicted_valid),
    .evicted_addr  (evicted_addr),
    .evicted_data  (evicted_data)
  );

  miss_queue i_miss_queue (
    .clock            (clock),
    .reset            (reset),
    .lookup_miss      (lookup_miss),
    .rd_addr          (rd_addr),
    .refill_en        (refill_en),
    .refill_addr      (refill_addr),
    .refill_data      (refill_data),
    .proc_mem_command (proc_mem_command),
    .proc_mem_addr    (proc_mem_addr),
    .mem_response     (mem_response),
    .mem_data         (mem_data),
    .mem_tag          (mem_tag)
  );

endmodule

// ==== verification/mem_model.sv ====
`timescale 1ns/100ps

module mem_model #(
  parameter int seed_init = 1
) (
  input  logic                                clock,
  input  logic                                reset,
  input  logic [1:0]                          proc_mem_command,
  input  logic [dcache_pkg::addr_width-1:0]   proc_mem_addr,
  output logic [dcache_pkg::mem_tag_bits-1:0] mem_response,
  output logic [dcache_pkg::data_width-1:0]   mem_data,
  output logic [dcache_pkg::mem_tag_bits-1:0] mem_tag
);

  integer      seed     = seed_init;
  logic        grant    = 1'b0;
  logic [3:0]  next_tag = 4'd1;
  logic [3:0]  tag_out  = 4'd0;
  logic [63:0] data_out = 64'd0;
  int          cycle    = 0;

  // loads waiting to return, oldest first
  logic [31:0] pend_addr [$];
  logic [3:0]  pend_tag  [$];
  int          pend_due  [$];

  assign mem_response = (proc_mem_command == dcache_pkg::bus_load && grant) ? next_tag : 4'd0;
  assign mem_tag      = tag_out;
  assign mem_data     = data_out;

  always @(posedge clock) begin
    logic        taken;
    logic [31:0] taken_addr;
    logic [3:0]  taken_tag;
    logic [31:0] draw;
    taken      = !reset && mem_response != 4'd0;
    taken_addr = proc_mem_addr;
    taken_tag  = mem_response;
    #1;
    tag_out = 4'd0;
    if (reset) begin
      pend_addr.delete();
      pend_tag.delete();
      pend_due.delete();
      next_tag = 4'd1;
      cycle    = 0;
    end else begin
      cycle = cycle + 1;
      if (pend_due.size() != 0 && pend_due[0] <= cycle) begin
        tag_out  = pend_tag.pop_front();
        data_out = {pend_addr[0], ~pend_addr[0]};
        void'(pend_addr.pop_front());
        void'(pend_due.pop_front());
      end
      if (taken) begin
        // return 2 to 6 cycles after acceptance
        draw = $random(seed);
        pend_addr.push_back(taken_addr);
        pend_tag.push_back(taken_tag);
        pend_due.push_back(cycle + 2 + int'(draw % 5));
        next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
      end
    end
    draw  = $random(seed);
    grant = draw[0];
  end

endmodule

// ==== verification/dcache_tb.sv ====
`timescale 1ns/100ps

module dcache_tb;

  localparam int seed_value   = 25;
  localparam int reset_cycles = 16;
  localparam int test_cycles  = 2000;
  localparam int window_words = 64;
  // room for the closing sweep over the window
  localparam int sweep_cycles = window_words * 12;
  localparam int timeout_ns   = (reset_cycles + test_cycles + sweep_cycles + 500) * 8;
  localparam logic [31:0] base_addr = 32'h0000_4000;

  logic        clock;
  logic        reset;
  logic        rd_en;
  logic [31:0] rd_addr;
  logic [63:0] rd_data;
  logic        rd_valid;
  logic        rd_miss_valid;
  logic [31:0] rd_miss_addr;
  logic [63:0] rd_miss_data;
  logic        wr_en;
  logic [31:0] wr_addr;
  logic [63:0] wr_data;
  logic        evicted_valid;
  logic [31:0] evicted_addr;
  logic [63:0] evicted_data;
  logic [1:0]  proc_mem_command;
  logic [31:0] proc_mem_addr;
  logic [3:0]  mem_response;
  logic [63:0] mem_data;
  logic [3:0]  mem_tag;

  integer      seed = seed_value;
  logic        hit;
  logic [31:0] op;

  // reference model with the dirty lines as keys of written
  logic [63:0] written  [logic [31:0]];
  bit          missed   [logic [31:0]];
  bit          inflight [logic [31:0]];

  dcache i_dcache (.*);

  mem_model #(.seed_init(seed_value)) i_mem_model (.*);

  always #4 clock = ~clock;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic compare(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("ERR %0t %s: got %h, expected %h", $time, name, actual, expected));
    end
  endtask

  function automatic logic [63:0] mem_word(input logic [31:0] addr);
    return {addr, ~addr};
  endfunction

  function automatic logic [63:0] expected_word(input logic [31:0] addr);
    if (written.exists(addr)) begin
      return written[addr];
    end
    return mem_word(addr);
  endfunction

  function automatic logic [31:0] window_addr(input logic [31:0] r);
    return base_addr + {23'd0, r[5:0], 3'b000};
  endfunction

  //////////////////////////////
  // output checks
  //////////////////////////////
  always @(posedge clock) begin : check_outputs
    logic dup;
    if (!reset) begin
      if (evicted_valid) begin
        if (!written.exists(evicted_addr)) begin
          abort_run($sformatf("eviction of %h, a line that was never written", evicted_addr));
        end
        compare("evicted_data", evicted_data, written[evicted_addr]);
        written.delete(evicted_addr);
      end
      if (rd_en && rd_valid) begin
        compare("rd_data", rd_data, expected_word(rd_addr));
      end
      // a line still queued swallows the miss, even on its refill cycle
      dup = rd_en && !rd_valid && missed.exists(rd_addr);
      if (proc_mem_command == dcache_pkg::bus_load && mem_response != 4'd0) begin
        if (!missed.exists(proc_mem_addr)) begin
          abort_run($sformatf("load of %h that no read missed", proc_mem_addr));
        end
        if (inflight.exists(proc_mem_addr)) begin
          abort_run($sformatf("second load of %h while one is in flight", proc_mem_addr));
        end
        inflight[proc_mem_addr] = 1'b1;
      end
      if (rd_miss_valid) begin
        if (!missed.exists(rd_miss_addr)) begin
          abort_run($sformatf("miss completion for %h with no open miss", rd_miss_addr));
        end
        compare("rd_miss_data", rd_miss_data, mem_word(rd_miss_addr));
        missed.delete(rd_miss_addr);
        inflight.delete(rd_miss_addr);
      end
      if (rd_en && !rd_valid && !dup && missed.num() < dcache_pkg::queue_depth) begin
        missed[rd_addr] = 1'b1;
      end
      if (wr_en) begin
        written[wr_addr] = wr_data;
      end
    end
  end

  initial begin
    #timeout_ns;
    abort_run("watchdog expired before the run completed");
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////
  initial begin
    clock   = 1'b0;
    reset   = 1'b1;
    rd_en   = 1'b0;
    rd_addr = '0;
    wr_en   = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    repeat (reset_cycles) @(posedge clock);
    #1;
    reset = 1'b0;

    // quiet until the first request
    repeat (4) begin
      @(posedge clock);
      #2;
      compare("rd_miss_valid", 64'(rd_miss_valid), 64'd0);
      compare("evicted_valid", 64'(evicted_valid), 64'd0);
      compare("proc_mem_command", 64'(proc_mem_command), 64'(dcache_pkg::bus_none));
    end

    repeat (test_cycles) begin
      @(posedge clock);
      #1;
      op      = $random(seed);
      rd_en   = op[0];
      // writes on about a quarter of the cycles
      wr_en   = op[1] & op[2];
      rd_addr = window_addr($random(seed));
      wr_addr = window_addr($random(seed));
      wr_data = {$random(seed), $random(seed)};
    end

    // every word of the window must end up hitting
    for (int w = 0; w < window_words; w++) begin
      hit = 1'b0;
      while (!hit) begin
        @(posedge clock);
        #1;
        wr_en   = 1'b0;
        rd_en   = 1'b1;
        rd_addr = window_addr(w);
        #1;
        hit = rd_valid;
      end
    end
    @(posedge clock);
    #1;
    rd_en = 1'b0;
    while (missed.num() != 0) begin
      @(posedge clock);
      #2;
    end
    // drained queue issues no further loads
    compare("proc_mem_command", 64'(proc_mem_command), 64'(dcache_pkg::bus_none));
    $display("Test passed");
    $finish;
  end

endmodule

// ==== list.f ====
rtl/dcache_pkg.sv
rtl/dcache_array.sv
rtl/miss_queue.sv
rtl/dcache.sv
verification/mem_model.sv
verification/dcache_tb.sv

// ==== Makefile ====
SIM = obj_dir/Vdcache_tb

run: $(SIM)
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -qx "Test passed"

$(SIM): list.f $(wildcard rtl/*.sv verification/*.sv)
	verilator --binary -Wno-fatal --top-module dcache_tb -f list.f -o Vdcache_tb

clean:
	rm -rf obj_dir

.PHONY: run clean
